/* sources.f */
source/alpha_pkg.sv
source/inst_decoder.sv
source/id_stage.sv
source/reg_file.sv
source/ex_stage.sv
source/wb_stage.sv
source/alpha_dual_core.sv
bench/alpha_dual_core_tb.sv

/* bench/core_input.txt */
# inst_1 valid_1 pc_1 inst_2 valid_2 pc_2, then per slot: valid dest result taken target flags
# flags = {rd_mem, wr_mem, illegal}; last column is the test number
43e0b401 1 100 43f91402 1 104 1 01 5 0 0 0 1 02 c8 0 0 0 1
47e1f403 1 108 43e07404 1 10c 1 03 f 0 0 0 1 04 3 0 0 0 1
40220525 1 110 4c410406 1 114 1 05 ffffffffffffff3d 0 0 0 1 06 3e8 0 0 0 1
48640727 1 118 408303a8 1 11c 1 07 78 0 0 0 1 08 1 0 0 0 1
48a09789 1 120 48a7968a 1 124 1 09 fffffffffffffff3 0 0 0 1 0a f 0 0 0 1
40a109ab 1 128 40a107ac 1 12c 1 0b 1 0 0 0 1 0c 0 0 0 0 1
44c7080d 1 130 44dff00e 1 134 1 0d 390 0 0 0 1 0e e8 0 0 0 1
44c3010f 1 138 47e40510 1 13c 1 0f 3e0 0 0 0 1 10 fffffffffffffffc 0 0 0 1
410035b1 1 140 412a0db2 1 144 1 11 1 0 0 0 1 12 1 0 0 0 1
43e23414 1 148 43e45414 1 14c 1 14 11 0 0 0 1 14 22 0 0 0 2
47ff0915 1 150 47e67416 1 154 1 15 ffffffffffffffff 0 0 0 1 16 33 0 0 0 2
469f0417 1 158 42803418 1 15c 1 17 22 0 0 0 1 18 23 0 0 0 2
23260100 1 160 a746fff8 1 164 1 19 4e8 0 0 0 1 1a 3e0 0 0 4 3
b4220010 1 168 0 0 0 1 1f d8 0 0 2 0 00 0 0 0 0 3
c3600004 1 1000 d39ffffe 1 1004 1 1b 1004 1 1014 0 1 1c 1008 1 1000 0 4
6ba54000 1 2000 e5800008 1 2004 1 1d 2004 1 ffffffffffffff3c 0 1 1f 2028 1 2028 0 4
f5800008 1 2008 e8bfffff 1 200c 1 1f 202c 0 202c 0 1 1f 200c 1 200c 0 4
58000000 1 3000 43ff0fe1 1 3004 0 00 0 0 0 1 0 00 0 0 0 1 5
0 0 0 0 0 0 0 00 0 0 0 0 0 00 0 0 0 0 5
00000555 1 4000 43e0341e 1 4004 0 00 0 0 0 0 0 00 0 0 0 0 6
43e0f401 1 4008 43e0341e 1 400c 0 00 0 0 0 0 0 00 0 0 0 0 6

/* bench/alpha_dual_core_tb.sv */
// testbench for the two-wide alpha core
// replays instruction pairs from a vector file and checks both retire slots
`timescale 1ns/1ps
`default_nettype none

module alpha_dual_core_tb import alpha_pkg::*; ();

  localparam int max_vectors  = 64;
  localparam int halt_timeout = 20;   // cycles
  localparam logic [31:0] halt_word = 32'h0000_0555;   // call_pal with the halt function

  // expected retire fields of one slot
  typedef struct packed {
    logic        valid;
    logic [4:0]  dest_idx;
    logic [63:0] result;
    logic        taken;
    logic [63:0] target;
    logic [2:0]  flags;     // rd_mem, wr_mem, illegal
  } expect_t;

  // one line of the vector file
  typedef struct packed {
    logic [31:0] inst_1;
    logic        valid_1;
    logic [63:0] pc_1;
    logic [31:0] inst_2;
    logic        valid_2;
    logic [63:0] pc_2;
    expect_t     exp_1;
    expect_t     exp_2;
    logic [7:0]  test_num;
  } vector_t;

  logic        clock;
  logic        reset;
  logic [31:0] inst_1, inst_2;
  logic        inst_valid_1, inst_valid_2;
  logic [63:0] pc_1, pc_2;
  retire_t     retire_1, retire_2;
  logic        halted;
  logic [31:0] retired_count;

  vector_t     vectors [0:max_vectors-1];
  int          num_vectors;
  int          expected_retires;   // sum of valid bits in the file
  int          failures;
  int          checks;
  int          tests_run;
  int          test_failures;      // within the current test
  logic [7:0]  current_test;
  logic        halt_seen;          // a halt has retired so far
  int          seed_value;

  alpha_dual_core DUT (
    .clock(clock), .reset(reset),
    .inst_1(inst_1), .inst_valid_1(inst_valid_1), .pc_1(pc_1),
    .inst_2(inst_2), .inst_valid_2(inst_valid_2), .pc_2(pc_2),
    .retire_1(retire_1), .retire_2(retire_2),
    .halted(halted), .retired_count(retired_count)
  );

  always #2 clock = ~clock;   // 4 ns period

  ////////////////////////////////////////////////////////////
  // vector file
  ////////////////////////////////////////////////////////////
  task automatic load_vectors();
    int          fd;
    int          code;
    string       text;
    logic [63:0] f [0:18];
    fd = $fopen("bench/core_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the vector file bench/core_input.txt");
      failures++;
      return;
    end
    while (!$feof(fd) && num_vectors < max_vectors)
    begin
      code = $fgets(text, fd);
      if (code > 0 && text.len() > 1 && text.getc(0) != "#")   // skip comments, blanks
      begin
        code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                       f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
        if (code == 19)
        begin
          vectors[num_vectors].inst_1   = f[0][31:0];
          vectors[num_vectors].valid_1  = f[1][0];
          vectors[num_vectors].pc_1     = f[2];
          vectors[num_vectors].inst_2   = f[3][31:0];
          vectors[num_vectors].valid_2  = f[4][0];
          vectors[num_vectors].pc_2     = f[5];
          vectors[num_vectors].exp_1    = '{f[6][0], f[7][4:0], f[8], f[9][0], f[10], f[11][2:0]};
          vectors[num_vectors].exp_2    = '{f[12][0], f[13][4:0], f[14], f[15][0], f[16],
                                            f[17][2:0]};
          vectors[num_vectors].test_num = f[18][7:0];
          expected_retires += f[6][0] + f[12][0];
          num_vectors++;
        end
        else
        begin
          $display("malformed line in the vector file: %s", text);
          failures++;
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and checks
  ////////////////////////////////////////////////////////////
  task automatic drive_pair(input vector_t v);
    inst_1       <= v.valid_1 ? v.inst_1 : $urandom;   // junk word in a dead slot
    inst_valid_1 <= v.valid_1;
    pc_1         <= v.pc_1;
    inst_2       <= v.valid_2 ? v.inst_2 : $urandom;
    inst_valid_2 <= v.valid_2;
    pc_2         <= v.pc_2;
  endtask

  task automatic drive_idle();
    inst_1       <= $urandom;
    inst_valid_1 <= 1'b0;
    pc_1         <= 64'd0;
    inst_2       <= $urandom;
    inst_valid_2 <= 1'b0;
    pc_2         <= 64'd0;
  endtask

  // a live slot carrying the halt call
  function automatic logic is_halt(input logic valid, input logic [31:0] inst);
    return valid && (inst == halt_word);
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    failures++;
    test_failures++;
  endtask

  task automatic check_slot(input retire_t got, input expect_t exp, input logic exp_halt,
                            input string slot);
    checks++;
    assert (got.valid == exp.valid)
    else report_mismatch({slot, ".valid"}, got.valid, exp.valid);
    assert ({got.rd_mem, got.wr_mem, got.illegal} == exp.flags)
    else report_mismatch({slot, ".flags"}, {got.rd_mem, got.wr_mem, got.illegal}, exp.flags);
    assert (got.taken == exp.taken)
    else report_mismatch({slot, ".taken"}, got.taken, exp.taken);
    assert (got.halt == exp_halt)
    else report_mismatch({slot, ".halt"}, got.halt, exp_halt);
    // data fields only mean something for a real retirement
    if (exp.valid)
    begin
      assert (got.dest_idx == exp.dest_idx)
      else report_mismatch({slot, ".dest_idx"}, got.dest_idx, exp.dest_idx);
      assert (got.result == exp.result)
      else report_mismatch({slot, ".result"}, got.result, exp.result);
      assert (got.target == exp.target)
      else report_mismatch({slot, ".target"}, got.target, exp.target);
    end
  endtask

  task automatic close_test();
    if (current_test != 0)
    begin
      if (test_failures == 0)
        $display("test %0d passed", current_test);
      else
        $display("test %0d failed with %0d mismatches", current_test, test_failures);
      tests_run++;
    end
    test_failures = 0;
  endtask

  task automatic check_line(input int idx);
    logic halt_1;
    logic halt_2;
    if (vectors[idx].test_num != current_test)   // new test starts
    begin
      close_test();
      current_test = vectors[idx].test_num;
    end
    halt_1 = is_halt(vectors[idx].valid_1, vectors[idx].inst_1);
    halt_2 = is_halt(vectors[idx].valid_2, vectors[idx].inst_2);
    if (halt_1 || halt_2)
      halt_seen = 1'b1;   // sticky from this retirement on
    check_slot(retire_1, vectors[idx].exp_1, halt_1, "retire_1");
    check_slot(retire_2, vectors[idx].exp_2, halt_2, "retire_2");
    assert (halted == halt_seen)
    else report_mismatch("halted", halted, halt_seen);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    int wait_cycles;
    clock        = 1'b0;
    reset        = 1'b1;
    inst_1       = 32'd0;
    inst_valid_1 = 1'b0;
    pc_1         = 64'd0;
    inst_2       = 32'd0;
    inst_valid_2 = 1'b0;
    pc_2         = 64'd0;
    current_test = 8'd0;
    halt_seen    = 1'b0;
    seed_value   = $urandom(85);

    load_vectors();

    repeat (10) @(posedge clock);
    reset <= 1'b0;

    // line i retires two cycles after it is driven
    for (int cycle = 0; cycle < num_vectors + 2; cycle++)
    begin
      @(posedge clock);
      if (cycle < num_vectors)
        drive_pair(vectors[cycle]);
      else
        drive_idle();
      @(negedge clock);   // outputs settled mid-cycle
      if (cycle >= 2)
        check_line(cycle - 2);
    end
    close_test();

    wait_cycles = 0;
    while (!halted && wait_cycles < halt_timeout)
    begin
      @(negedge clock);
      wait_cycles++;
    end
    if (!halted)
    begin
      $display("timed out waiting for the core to halt");
      failures++;
    end

    assert (retired_count == expected_retires)
    else report_mismatch("retired_count", retired_count, expected_retires);

    $display("%0d tests, %0d slot checks, %0d failures", tests_run, checks, failures);
    if (failures == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* source/alpha_dual_core.sv */
// two-wide alpha integer core
// decode, register file, execute and result stages
`timescale 1ns/1ps
`default_nettype none

module alpha_dual_core import alpha_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] inst_1,
  input  logic        inst_valid_1,
  input  logic [63:0] pc_1,
  input  logic [31:0] inst_2,
  input  logic        inst_valid_2,
  input  logic [63:0] pc_2,
  output retire_t     retire_1,
  output retire_t     retire_2,
  output logic        halted,
  output logic [31:0] retired_count
);

  ctrl_t       ctrl_1, ctrl_2;
  logic [4:0]  ra_idx_1, rb_idx_1, ra_idx_2, rb_idx_2;
  logic [63:0] ra_val_1, rb_val_1, ra_val_2, rb_val_2;
  issue_t      issue_1, issue_2;
  retire_t     exec_1, exec_2;
  logic        we_1, we_2;
  logic [4:0]  wr_idx_1, wr_idx_2;
  logic [63:0] wr_data_1, wr_data_2;

  id_stage id_stage_0 (
    .inst_1(inst_1), .inst_2(inst_2),
    .inst_valid_1(inst_valid_1), .inst_valid_2(inst_valid_2),
    .ctrl_1(ctrl_1), .ctrl_2(ctrl_2),
    .ra_idx_1(ra_idx_1), .rb_idx_1(rb_idx_1),
    .ra_idx_2(ra_idx_2), .rb_idx_2(rb_idx_2)
  );

  reg_file reg_file_0 (
    .clock(clock), .reset(reset),
    .ra_idx_1(ra_idx_1), .rb_idx_1(rb_idx_1), .ra_idx_2(ra_idx_2), .rb_idx_2(rb_idx_2),
    .ra_val_1(ra_val_1), .rb_val_1(rb_val_1), .ra_val_2(ra_val_2), .rb_val_2(rb_val_2),
    .we_1(we_1), .wr_idx_1(wr_idx_1), .wr_data_1(wr_data_1),
    .we_2(we_2), .wr_idx_2(wr_idx_2), .wr_data_2(wr_data_2)
  );

  // issue slots for execute
  assign issue_1 = '{ctrl: ctrl_1, inst: inst_1, pc: pc_1,
                     rega_val: ra_val_1, regb_val: rb_val_1};
  assign issue_2 = '{ctrl: ctrl_2, inst: inst_2, pc: pc_2,
                     rega_val: ra_val_2, regb_val: rb_val_2};

  ex_stage ex_stage_0 (
    .clock(clock), .reset(reset),
    .issue_1(issue_1), .issue_2(issue_2),
    .exec_1(exec_1), .exec_2(exec_2)
  );

  wb_stage wb_stage_0 (
    .clock(clock), .reset(reset),
    .exec_1(exec_1), .exec_2(exec_2),
    .retire_1(retire_1), .retire_2(retire_2),
    .we_1(we_1), .wr_idx_1(wr_idx_1), .wr_data_1(wr_data_1),
    .we_2(we_2), .wr_idx_2(wr_idx_2), .wr_data_2(wr_data_2),
    .halted(halted), .retired_count(retired_count)
  );

endmodule

`default_nettype wire

/* source/wb_stage.sv */
// result stage
// ex/wb register, halt kill, register writes and retire counting
`timescale 1ns/1ps
`default_nettype none

module wb_stage import alpha_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  retire_t     exec_1,
  input  retire_t     exec_2,
  output retire_t     retire_1,
  output retire_t     retire_2,
  output logic        we_1,
  output logic [4:0]  wr_idx_1,
  output logic [63:0] wr_data_1,
  output logic        we_2,
  output logic [4:0]  wr_idx_2,
  output logic [63:0] wr_data_2,
  output logic        halted,
  output logic [31:0] retired_count
);

  retire_t next_1, next_2;

  // halts retire invalid; a dead slot retires nothing
  function automatic retire_t kill_slot(input retire_t e, input logic live);
    retire_t r;
    r = e;
    r.valid   = e.valid & ~e.halt & live;
    r.illegal = e.illegal & live;
    r.taken   = e.taken & r.valid;
    return r;
  endfunction

  always_comb
  begin
    next_1 = kill_slot(exec_1, ~halted);
    next_2 = kill_slot(exec_2, ~halted & ~exec_1.halt);  // slot 1 halt kills slot 2
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      retire_1      <= '0;
      retire_2      <= '0;
      halted        <= 1'b0;
      retired_count <= 32'd0;
    end
    else
    begin
      retire_1      <= next_1;
      retire_2      <= next_2;
      halted        <= halted | exec_1.halt | exec_2.halt;  // sticky until reset
      retired_count <= retired_count + 32'(next_1.valid) + 32'(next_2.valid);
    end
  end

  // register file writes during the retire cycle
  assign we_1      = retire_1.valid && (retire_1.dest_idx != zero_reg);
  assign wr_idx_1  = retire_1.dest_idx;
  assign wr_data_1 = retire_1.result;
  assign we_2      = retire_2.valid && (retire_2.dest_idx != zero_reg);
  assign wr_idx_2  = retire_2.dest_idx;
  assign wr_data_2 = retire_2.result;

endmodule

`default_nettype wire

/* source/ex_stage.sv */
// execute stage
// id/ex register, two alu lanes, branch condition and target
`timescale 1ns/1ps
`default_nettype none

module ex_stage import alpha_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  issue_t  issue_1,
  input  issue_t  issue_2,
  output retire_t exec_1,
  output retire_t exec_2
);

  issue_t id_ex_1, id_ex_2;

  ////////////////////////////////////////////////////////////
  // one lane: operand muxes, alu, branch evaluation
  ////////////////////////////////////////////////////////////
  function automatic retire_t exec_lane(input issue_t s);
    logic [63:0] opa, opb, alu, npc;
    logic        cond;
    retire_t     r;

    npc = s.pc + 64'd4;

    case (s.ctrl.opa_sel)
      opa_rega:     opa = s.rega_val;
      opa_mem_disp: opa = {{48{s.inst[15]}}, s.inst[15:0]};  // sign-extended disp
      opa_npc:      opa = npc;
      default:      opa = ~64'h3;                            // jump alignment mask
    endcase

    case (s.ctrl.opb_sel)
      opb_alu_imm: opb = {56'd0, s.inst[20:13]};              // zero-extended literal
      opb_br_disp: opb = {{41{s.inst[20]}}, s.inst[20:0], 2'b00};
      default:     opb = s.regb_val;
    endcase

    case (s.ctrl.alu_func)
      alu_addq:   alu = opa + opb;
      alu_subq:   alu = opa - opb;
      alu_mulq:   alu = opa * opb;        // low 64 bits
      alu_cmpeq:  alu = 64'(opa == opb);
      alu_cmpult: alu = 64'(opa < opb);
      alu_cmpule: alu = 64'(opa <= opb);
      alu_cmplt:  alu = 64'($signed(opa) < $signed(opb));
      alu_cmple:  alu = 64'($signed(opa) <= $signed(opb));
      alu_and:    alu = opa & opb;
      alu_bic:    alu = opa & ~opb;
      alu_bis:    alu = opa | opb;
      alu_ornot:  alu = opa | ~opb;
      alu_xor:    alu = opa ^ opb;
      alu_eqv:    alu = opa ^ ~opb;
      alu_srl:    alu = opa >> opb[5:0];
      alu_sll:    alu = opa << opb[5:0];
      alu_sra:    alu = $signed(opa) >>> opb[5:0];
      default:    alu = opa;
    endcase

    // condition on ra, low opcode bits pick the test
    case (s.inst[28:26])
      3'd0:    cond = ~s.rega_val[0];                          // blbc
      3'd1:    cond = (s.rega_val == 64'd0);                   // beq
      3'd2:    cond = s.rega_val[63];                          // blt
      3'd3:    cond = s.rega_val[63] | (s.rega_val == 64'd0);  // ble
      3'd4:    cond = s.rega_val[0];                           // blbs
      3'd5:    cond = (s.rega_val != 64'd0);                   // bne
      3'd6:    cond = ~s.rega_val[63];                         // bge
      default: cond = ~s.rega_val[63] & (s.rega_val != 64'd0); // bgt
    endcase

    r.valid    = s.ctrl.valid;
    r.halt     = s.ctrl.halt;
    r.illegal  = s.ctrl.illegal;
    r.rd_mem   = s.ctrl.rd_mem;
    r.wr_mem   = s.ctrl.wr_mem;
    r.dest_idx = s.ctrl.dest_idx;
    r.taken    = s.ctrl.uncond_branch | (s.ctrl.cond_branch & cond);
    r.result   = s.ctrl.uncond_branch ? npc : alu;    // link for jsr/br/bsr
    r.target   = (s.ctrl.uncond_branch | s.ctrl.cond_branch) ? alu : 64'd0;
    return r;
  endfunction

  // id/ex register, control cleared on reset
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      id_ex_1.ctrl <= '0;
      id_ex_2.ctrl <= '0;
    end
    else
    begin
      id_ex_1 <= issue_1;
      id_ex_2 <= issue_2;
    end
  end

  assign exec_1 = exec_lane(id_ex_1);
  assign exec_2 = exec_lane(id_ex_2);

endmodule

`default_nettype wire

/* source/reg_file.sv */
// integer register file, 32 x 64
// four reads with write-through, two writes with slot 2 priority
`timescale 1ns/1ps
`default_nettype none

module reg_file import alpha_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  ra_idx_1,
  input  logic [4:0]  rb_idx_1,
  input  logic [4:0]  ra_idx_2,
  input  logic [4:0]  rb_idx_2,
  output logic [63:0] ra_val_1,
  output logic [63:0] rb_val_1,
  output logic [63:0] ra_val_2,
  output logic [63:0] rb_val_2,
  input  logic        we_1,
  input  logic [4:0]  wr_idx_1,
  input  logic [63:0] wr_data_1,
  input  logic        we_2,
  input  logic [4:0]  wr_idx_2,
  input  logic [63:0] wr_data_2
);

  logic [63:0] regs [0:30];   // r31 has no storage

  // newest data first: slot 2 write, slot 1 write, array
  function automatic logic [63:0] read_port(input logic [4:0] idx);
    if (idx == zero_reg)
      return 64'd0;
    else if (we_2 && wr_idx_2 == idx)
      return wr_data_2;
    else if (we_1 && wr_idx_1 == idx)
      return wr_data_1;
    else
      return regs[idx];
  endfunction

  always_comb
  begin
    ra_val_1 = read_port(ra_idx_1);
    rb_val_1 = read_port(rb_idx_1);
    ra_val_2 = read_port(ra_idx_2);
    rb_val_2 = read_port(rb_idx_2);
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < 31; i++)
        regs[i] <= 64'd0;
    end
    else
    begin
      if (we_1 && wr_idx_1 != zero_reg)
        regs[wr_idx_1] <= wr_data_1;
      if (we_2 && wr_idx_2 != zero_reg)
        regs[wr_idx_2] <= wr_data_2;   // later write wins on a clash
    end
  end

endmodule

`default_nettype wire

/* source/id_stage.sv */
// dual decode stage
// two independent decoders, register fields and destination select
`timescale 1ns/1ps
`default_nettype none

module id_stage import alpha_pkg::*; (
  input  logic [31:0] inst_1,
  input  logic [31:0] inst_2,
  input  logic        inst_valid_1,
  input  logic        inst_valid_2,
  output ctrl_t       ctrl_1,
  output ctrl_t       ctrl_2,
  output logic [4:0]  ra_idx_1,
  output logic [4:0]  rb_idx_1,
  output logic [4:0]  ra_idx_2,
  output logic [4:0]  rb_idx_2
);

  ctrl_t       dec_ctrl_1, dec_ctrl_2;
  dest_sel_e   dest_sel_1, dest_sel_2;
  logic [4:0]  rc_idx_1, rc_idx_2;

  // destination mux, r31 when nothing is written
  function automatic logic [4:0] dest_index(input dest_sel_e sel, input logic [4:0] ra,
                                            input logic [4:0] rc);
    case (sel)
      dest_rega: return ra;
      dest_regc: return rc;
      default:   return zero_reg;
    endcase
  endfunction

  assign ra_idx_1 = inst_1[25:21];
  assign rb_idx_1 = inst_1[20:16];
  assign rc_idx_1 = inst_1[4:0];
  assign ra_idx_2 = inst_2[25:21];
  assign rb_idx_2 = inst_2[20:16];
  assign rc_idx_2 = inst_2[4:0];

  inst_decoder decoder_1 (.inst(inst_1), .valid_in(inst_valid_1),
                          .ctrl(dec_ctrl_1), .dest_sel(dest_sel_1));
  inst_decoder decoder_2 (.inst(inst_2), .valid_in(inst_valid_2),
                          .ctrl(dec_ctrl_2), .dest_sel(dest_sel_2));

  always_comb
  begin
    ctrl_1 = dec_ctrl_1;
    ctrl_1.dest_idx = dest_index(dest_sel_1, ra_idx_1, rc_idx_1);
    ctrl_2 = dec_ctrl_2;
    ctrl_2.dest_idx = dest_index(dest_sel_2, ra_idx_2, rc_idx_2);
  end

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
// instruction decoder
// turns one alpha instruction word into datapath control, noop by default
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import alpha_pkg::*; (
  input  logic [31:0] inst,
  input  logic        valid_in,   // low: outputs stay a noop
  output ctrl_t       ctrl,       // dest_idx left at zero_reg, id_stage fills it
  output dest_sel_e   dest_sel
);

  always_comb
  begin
    // noop defaults
    ctrl = '0;
    ctrl.dest_idx = zero_reg;
    dest_sel = dest_none;

    if (valid_in)
    begin
      case (inst[31:26]) inside
        pal_inst:
        begin
          if (inst[25:0] == halt_code)
            ctrl.halt = 1'b1;
          else
            ctrl.illegal = 1'b1;      // other pal calls unsupported
        end

        ////////////////////////////////////////////////////////////
        // integer operate groups
        ////////////////////////////////////////////////////////////
        inta_grp, intl_grp, ints_grp, intm_grp:
        begin
          ctrl.opa_sel = opa_rega;
          ctrl.opb_sel = inst[12] ? opb_alu_imm : opb_regb;  // literal form
          dest_sel = dest_regc;
          // group low bits keep addq/bis/mulq apart
          case ({inst[27:26], inst[11:5]})
            {inta_grp[1:0], addq_fn}:   ctrl.alu_func = alu_addq;
            {inta_grp[1:0], subq_fn}:   ctrl.alu_func = alu_subq;
            {inta_grp[1:0], cmpeq_fn}:  ctrl.alu_func = alu_cmpeq;
            {inta_grp[1:0], cmpult_fn}: ctrl.alu_func = alu_cmpult;
            {inta_grp[1:0], cmpule_fn}: ctrl.alu_func = alu_cmpule;
            {inta_grp[1:0], cmplt_fn}:  ctrl.alu_func = alu_cmplt;
            {inta_grp[1:0], cmple_fn}:  ctrl.alu_func = alu_cmple;
            {intl_grp[1:0], and_fn}:    ctrl.alu_func = alu_and;
            {intl_grp[1:0], bic_fn}:    ctrl.alu_func = alu_bic;
            {intl_grp[1:0], bis_fn}:    ctrl.alu_func = alu_bis;
            {intl_grp[1:0], ornot_fn}:  ctrl.alu_func = alu_ornot;
            {intl_grp[1:0], xor_fn}:    ctrl.alu_func = alu_xor;
            {intl_grp[1:0], eqv_fn}:    ctrl.alu_func = alu_eqv;
            {ints_grp[1:0], srl_fn}:    ctrl.alu_func = alu_srl;
            {ints_grp[1:0], sll_fn}:    ctrl.alu_func = alu_sll;
            {ints_grp[1:0], sra_fn}:    ctrl.alu_func = alu_sra;
            {intm_grp[1:0], mulq_fn}:   ctrl.alu_func = alu_mulq;
            default:                    ctrl.illegal = 1'b1;  // unknown function
          endcase
        end

        jsr_grp:
        begin
          // all four jump flavours behave alike
          ctrl.opa_sel = opa_not3;
          ctrl.opb_sel = opb_regb;
          ctrl.alu_func = alu_and;    // word-align rb
          dest_sel = dest_rega;       // link register
          ctrl.uncond_branch = 1'b1;
        end

        lda_inst, ldq_inst, stq_inst:
        begin
          ctrl.opa_sel = opa_mem_disp;
          ctrl.opb_sel = opb_regb;
          ctrl.alu_func = alu_addq;   // disp + rb
          ctrl.rd_mem = (inst[31:26] == ldq_inst);
          ctrl.wr_mem = (inst[31:26] == stq_inst);
          dest_sel = ctrl.wr_mem ? dest_none : dest_rega;  // store writes nothing
        end

        ////////////////////////////////////////////////////////////
        // branches
        ////////////////////////////////////////////////////////////
        [6'h30:6'h3f]:
        begin
          ctrl.opa_sel = opa_npc;
          ctrl.opb_sel = opb_br_disp;
          ctrl.alu_func = alu_addq;   // npc + disp*4
          case (inst[31:26])
            fbeq_inst, fblt_inst, fble_inst,
            fbne_inst, fbge_inst, fbgt_inst:
              ctrl.illegal = 1'b1;    // no floating point
            br_inst, bsr_inst:
            begin
              dest_sel = dest_rega;
              ctrl.uncond_branch = 1'b1;
            end
            default:
              ctrl.cond_branch = 1'b1;  // integer conditionals
          endcase
        end

        default: ctrl.illegal = 1'b1;   // fp groups, misc, other loads
      endcase
    end

    ctrl.valid = valid_in & ~ctrl.illegal;
  end

endmodule

`default_nettype wire

/* source/alpha_pkg.sv */
// alpha core shared definitions
// opcodes, function codes, mux selects and the stage structs
`default_nettype none

package alpha_pkg;

  ////////////////////////////////////////////////////////////
  // major opcodes, inst[31:26]
  ////////////////////////////////////////////////////////////
  localparam logic [5:0] pal_inst  = 6'h00;
  localparam logic [5:0] lda_inst  = 6'h08;
  localparam logic [5:0] inta_grp  = 6'h10;  // add/sub/compare
  localparam logic [5:0] intl_grp  = 6'h11;  // logical
  localparam logic [5:0] ints_grp  = 6'h12;  // shifts
  localparam logic [5:0] intm_grp  = 6'h13;  // multiply
  localparam logic [5:0] jsr_grp   = 6'h1a;  // jmp, jsr, ret, jsr_co
  localparam logic [5:0] ldq_inst  = 6'h29;
  localparam logic [5:0] stq_inst  = 6'h2d;
  localparam logic [5:0] br_inst   = 6'h30;
  localparam logic [5:0] fbeq_inst = 6'h31;
  localparam logic [5:0] fblt_inst = 6'h32;
  localparam logic [5:0] fble_inst = 6'h33;
  localparam logic [5:0] bsr_inst  = 6'h34;
  localparam logic [5:0] fbne_inst = 6'h35;
  localparam logic [5:0] fbge_inst = 6'h36;
  localparam logic [5:0] fbgt_inst = 6'h37;

  // integer function codes, inst[11:5]
  localparam logic [6:0] addq_fn   = 7'h20;
  localparam logic [6:0] subq_fn   = 7'h29;
  localparam logic [6:0] cmpeq_fn  = 7'h2d;
  localparam logic [6:0] cmpult_fn = 7'h1d;
  localparam logic [6:0] cmpule_fn = 7'h3d;
  localparam logic [6:0] cmplt_fn  = 7'h4d;
  localparam logic [6:0] cmple_fn  = 7'h6d;
  localparam logic [6:0] and_fn    = 7'h00;
  localparam logic [6:0] bic_fn    = 7'h08;
  localparam logic [6:0] bis_fn    = 7'h20;
  localparam logic [6:0] ornot_fn  = 7'h28;
  localparam logic [6:0] xor_fn    = 7'h40;
  localparam logic [6:0] eqv_fn    = 7'h48;
  localparam logic [6:0] srl_fn    = 7'h34;
  localparam logic [6:0] sll_fn    = 7'h39;
  localparam logic [6:0] sra_fn    = 7'h3c;
  localparam logic [6:0] mulq_fn   = 7'h20;

  localparam logic [25:0] halt_code = 26'h0555;  // call_pal halt
  localparam logic [4:0]  zero_reg  = 5'd31;     // r31 always reads zero

  ////////////////////////////////////////////////////////////
  // mux selects and alu functions
  ////////////////////////////////////////////////////////////
  typedef enum logic [4:0] {
    alu_addq, alu_subq, alu_mulq,
    alu_cmpeq, alu_cmpult, alu_cmpule, alu_cmplt, alu_cmple,
    alu_and, alu_bic, alu_bis, alu_ornot, alu_xor, alu_eqv,
    alu_srl, alu_sll, alu_sra
  } alu_func_e;

  typedef enum logic [1:0] {opa_rega, opa_mem_disp, opa_npc, opa_not3} opa_sel_e;
  typedef enum logic [1:0] {opb_regb, opb_alu_imm, opb_br_disp} opb_sel_e;
  typedef enum logic [1:0] {dest_none, dest_rega, dest_regc} dest_sel_e;

  // one decoded instruction
  typedef struct packed {
    opa_sel_e   opa_sel;
    opb_sel_e   opb_sel;
    alu_func_e  alu_func;
    logic [4:0] dest_idx;       // zero_reg when nothing is written
    logic       rd_mem;
    logic       wr_mem;
    logic       cond_branch;
    logic       uncond_branch;
    logic       halt;
    logic       illegal;
    logic       valid;          // slot valid and not illegal
  } ctrl_t;

  // one slot entering execute
  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] inst;
    logic [63:0] pc;
    logic [63:0] rega_val;
    logic [63:0] regb_val;
  } issue_t;

  // one slot leaving execute / the core
  typedef struct packed {
    logic        valid;
    logic        halt;          // seen by the result stage only
    logic [4:0]  dest_idx;
    logic [63:0] result;
    logic        taken;
    logic [63:0] target;
    logic        rd_mem;
    logic        wr_mem;
    logic        illegal;
  } retire_t;

endpackage

`default_nettype wire
